//--- Bender.yml
package:
  name: if_stage

sources:
  - files:
      - verilog/if_pkg.sv
      - verilog/freeze_hold.sv
      - verilog/fetch_issue.sv
      - verilog/if_stage_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/if_stage_tb.sv

//--- list.f
+incdir+verification
verilog/if_pkg.sv
verilog/freeze_hold.sv
verilog/fetch_issue.sv
verilog/if_stage_top.sv
verification/if_stage_tb.sv

//--- verification/if_stage_ref.svh
// Reference model of the fetch stage, included inside the testbench module; assumes 32-bit addresses.
`ifndef IF_STAGE_REF_SVH
`define IF_STAGE_REF_SVH

// Expected stage outputs for one cycle
typedef struct packed {
	logic [31:0] insn;
	logic [31:0] pc;
	logic        stall;
	logic        saving;
	logic        refetch;
	logic        exc_tlb;
	logic        exc_pf;
	logic        exc_be;
} expect_t;

// Model state between cycles
logic        m_saved  = 1'b0;
logic [31:0] m_insn   = 32'h1441_0000;
logic [31:0] m_addr   = 32'h0;
logic        m_err    = 1'b0;
logic [3:0]  m_tag    = 4'h0;
logic        m_bypass = 1'b0;

// Outputs from the live inputs and the model state
function automatic expect_t expected_outputs(input logic [31:0] dat, input logic ack,
	input logic err, input logic [31:0] adr, input logic [3:0] tag, input logic freeze,
	input logic flush, input logic nmd, input logic rfe);
	expect_t    e;
	logic       bypass;
	logic       err_now;
	logic [3:0] tag_now;
	// Flush starts it, address bit 0 ends it at once
	bypass = !adr[0] && (m_bypass || flush);
	if (nmd || rfe || bypass)
		e.insn = 32'h1441_0000;
	else if (m_saved)
		e.insn = m_err ? 32'h1441_0000 : m_insn;
	else if (ack)
		e.insn = dat;
	else
		e.insn = 32'h1461_0000;
	e.pc      = m_saved ? m_addr : {adr[31:2], 2'b00};
	e.stall   = !ack && !err && !m_saved;
	e.saving  = (ack || err) && freeze && !m_saved && !flush;
	e.refetch = m_saved && ack;
	// Held status takes over while a response is saved
	err_now   = m_saved ? m_err : err;
	tag_now   = m_saved ? m_tag : tag;
	e.exc_tlb = !nmd && err_now && (tag_now == 4'hd);
	e.exc_pf  = !nmd && err_now && (tag_now == 4'hc);
	e.exc_be  = !nmd && err_now && (tag_now == 4'hb);
	return e;
endfunction

// State step at the rising edge, inputs of the ending cycle
task automatic update_model(input logic rst, input logic [31:0] dat, input logic ack,
	input logic err, input logic [31:0] adr, input logic [3:0] tag, input logic freeze,
	input logic flush);
	logic capture;
	capture = (ack || err) && freeze && !m_saved;
	if (rst || flush) begin
		m_saved = 1'b0;
		m_insn  = 32'h1441_0000;
		m_addr  = 32'h0;
		m_err   = 1'b0;
		m_tag   = 4'h0;
	end else if (capture || !freeze) begin
		// Capture or plain follow, the flag tells them apart
		m_saved = capture;
		m_insn  = dat;
		m_addr  = {adr[31:2], 2'b00};
		m_err   = err;
		m_tag   = tag;
	end
	m_bypass = rst ? 1'b0 : (!adr[0] && (m_bypass || flush));
endtask

`endif

//--- verification/if_stage_tb.sv
// Self-checking testbench of the fetch stage; directed phases then 1,000 random cycles, capped at 2,400 cycles.

`timescale 1ns/1ps

module if_stage_tb;

	localparam int cycle_limit   = 2 * 1200;
	localparam int random_cycles = 1000;

	logic        clk;
	logic        reset_i;
	logic [31:0] ic_dat_i;
	logic        ic_ack_i;
	logic        ic_err_i;
	logic [31:0] ic_adr_i;
	logic [3:0]  ic_tag_i;
	logic        freeze_i;
	logic        flush_i;
	logic        no_more_dslot_i;
	logic        rfe_i;
	logic [31:0] insn_o;
	logic [31:0] pc_o;
	logic        stall_o;
	logic        saving_o;
	logic        refetch_o;
	logic        exc_tlb_miss_o;
	logic        exc_page_fault_o;
	logic        exc_bus_err_o;
	integer      seed;
	int          cycles = 0;
	int          errors = 0;

`include "if_stage_ref.svh"

	if_stage_top #(.ADDR_W(32)) DUT (.*);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// One cycle of inputs, 2 ns after the edge
	task automatic drive_cycle(input logic ack, input logic err, input logic [3:0] tag,
		input logic [31:0] dat, input logic [31:0] adr, input logic freeze,
		input logic flush, input logic nmd, input logic rfe);
		@(posedge clk);
		#2;
		ic_ack_i        = ack;
		ic_err_i        = err;
		ic_tag_i        = tag;
		ic_dat_i        = dat;
		ic_adr_i        = adr;
		freeze_i        = freeze;
		flush_i         = flush;
		no_more_dslot_i = nmd;
		rfe_i           = rfe;
	endtask

	////////////////////
	// Compare
	////////////////////

	// Samples 10 ns before the next edge, then steps the model
	initial begin
		expect_t e;
		forever begin
			@(posedge clk);
			#30;
			if (!reset_i) begin
				e = expected_outputs(ic_dat_i, ic_ack_i, ic_err_i, ic_adr_i, ic_tag_i,
					freeze_i, flush_i, no_more_dslot_i, rfe_i);
				check_value("insn_o", insn_o, e.insn);
				check_value("pc_o", pc_o, e.pc);
				check_value("stall_o", stall_o, e.stall);
				check_value("saving_o", saving_o, e.saving);
				check_value("refetch_o", refetch_o, e.refetch);
				check_value("exc_tlb_miss_o", exc_tlb_miss_o, e.exc_tlb);
				check_value("exc_page_fault_o", exc_page_fault_o, e.exc_pf);
				check_value("exc_bus_err_o", exc_bus_err_o, e.exc_be);
			end
			update_model(reset_i, ic_dat_i, ic_ack_i, ic_err_i, ic_adr_i, ic_tag_i,
				freeze_i, flush_i);
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic [31:0] r;
		seed    = 32'h786caf71;
		reset_i = 1'b1;
		{ic_dat_i, ic_adr_i, ic_tag_i, ic_ack_i, ic_err_i} = '0;
		{freeze_i, flush_i, no_more_dslot_i, rfe_i} = '0;
		repeat (16) @(posedge clk);
		#2;
		reset_i = 1'b0;
		// Idle cache, then acked words on misaligned addresses
		drive_cycle(0, 0, 0, 32'h0, 32'h100, 0, 0, 0, 0);
		#20;
		check_value("stall_o", stall_o, 1);
		check_value("insn_o", insn_o, 32'h1461_0000);
		for (int i = 0; i < 4; i++) begin
			drive_cycle(1, 0, 0, 32'h0a00_0000 + i, 32'h102 + 8 * i, 0, 0, 0, 0);
			#20;
			check_value("insn_o", insn_o, 32'h0a00_0000 + i);
			check_value("pc_o", pc_o, 32'h100 + 8 * i);
		end
		// Capture during freeze, then a second ack must refetch
		drive_cycle(1, 0, 0, 32'hcafe_0001, 32'h2002, 1, 0, 0, 0);
		#20;
		check_value("saving_o", saving_o, 1);
		drive_cycle(1, 0, 0, 32'hdead_0002, 32'h2006, 1, 0, 0, 0);
		#20;
		check_value("insn_o", insn_o, 32'hcafe_0001);
		check_value("pc_o", pc_o, 32'h2000);
		check_value("refetch_o", refetch_o, 1);
		drive_cycle(0, 0, 0, 32'h0, 32'h2008, 1, 0, 0, 0);
		drive_cycle(1, 0, 0, 32'hbeef_0003, 32'h2008, 0, 0, 0, 0);
		drive_cycle(1, 0, 0, 32'hbeef_0004, 32'h200c, 0, 0, 0, 0);
		#20;
		check_value("insn_o", insn_o, 32'hbeef_0004);
		// Each tag, only d, c and b trap
		for (int t = 4'ha; t <= 4'hd; t++) begin
			drive_cycle(0, 1, t, 32'h0, 32'h2010, 0, 0, 0, 0);
			#20;
			check_value("exc_tlb_miss_o", exc_tlb_miss_o, t == 4'hd);
			check_value("exc_page_fault_o", exc_page_fault_o, t == 4'hc);
			check_value("exc_bus_err_o", exc_bus_err_o, t == 4'hb);
		end
		// Held page fault, then no delay slot masks it
		drive_cycle(0, 1, 4'hc, 32'h0, 32'h2014, 1, 0, 0, 0);
		drive_cycle(0, 0, 0, 32'h0, 32'h2018, 1, 0, 0, 0);
		#20;
		check_value("exc_page_fault_o", exc_page_fault_o, 1);
		check_value("insn_o", insn_o, 32'h1441_0000);
		drive_cycle(0, 0, 0, 32'h0, 32'h2018, 1, 0, 1, 0);
		#20;
		check_value("exc_page_fault_o", exc_page_fault_o, 0);
		drive_cycle(0, 0, 0, 32'h0, 32'h201c, 0, 0, 0, 0);
		drive_cycle(1, 0, 0, 32'h1234_5678, 32'h2020, 0, 0, 0, 1);
		#20;
		check_value("insn_o", insn_o, 32'h1441_0000);
		drive_cycle(0, 1, 4'hd, 32'h0, 32'h2024, 0, 0, 1, 0);
		#20;
		check_value("exc_tlb_miss_o", exc_tlb_miss_o, 0);
		// Flush drops the held word and runs the bypass
		drive_cycle(1, 0, 0, 32'h5555_0001, 32'h3000, 1, 0, 0, 0);
		drive_cycle(0, 0, 0, 32'h0, 32'h3004, 1, 1, 0, 0);
		drive_cycle(0, 0, 0, 32'h0, 32'h3008, 1, 0, 0, 0);
		#20;
		check_value("stall_o", stall_o, 1);
		check_value("insn_o", insn_o, 32'h1441_0000);
		drive_cycle(1, 0, 0, 32'h6666_0001, 32'h300c, 0, 0, 0, 0);
		#20;
		check_value("insn_o", insn_o, 32'h1441_0000);
		drive_cycle(1, 0, 0, 32'h7777_0001, 32'h3011, 0, 0, 0, 0);
		#20;
		check_value("insn_o", insn_o, 32'h7777_0001);
		check_value("pc_o", pc_o, 32'h3010);
		// Random mix, ack and err kept apart
		for (int i = 0; i < random_cycles; i++) begin
			r = $random(seed);
			drive_cycle(r[0], !r[0] && r[1], r[5:2], $random(seed), $random(seed), r[6],
				r[10:8] == 3'd0, r[13:11] == 3'd0, r[16:14] == 3'd0);
		end
		drive_cycle(0, 0, 0, 32'h0, 32'h0, 0, 0, 0, 0);
		repeat (2) @(posedge clk);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/fetch_issue.sv
// Output merge of the fetch stage. All outputs are combinational from the cache port and held state; ack and err are assumed never high together.

`timescale 1ns/1ps

module fetch_issue
	import if_pkg::*;
#(
	// Fetch address width
	parameter int ADDR_W = 32
) (
	input  logic              clk,
	input  logic              reset_i,

	// Cache CPU port
	input  logic [insn_w-1:0] ic_dat_i,
	input  logic              ic_ack_i,
	input  logic              ic_err_i,
	input  logic [ADDR_W-1:0] ic_adr_i,
	input  logic [tag_w-1:0]  ic_tag_i,

	// Pipeline controls
	input  logic              freeze_i,
	input  logic              flush_i,
	input  logic              no_more_dslot_i,
	input  logic              rfe_i,

	// From the two hold instances
	input  fetch_word_t       held_word_i,
	input  ic_status_t        held_status_i,
	input  logic              saved_i,

	// Shared capture strobe for both holds
	output logic              capture_o,

	// To decode
	output logic [insn_w-1:0] insn_o,
	output logic [ADDR_W-1:0] pc_o,
	output logic              stall_o,
	output logic              saving_o,

	// To the PC generator
	output logic              refetch_o,

	// Fetch exceptions
	output logic              exc_tlb_miss_o,
	output logic              exc_page_fault_o,
	output logic              exc_bus_err_o
);

	////////////////////
	// Capture
	////////////////////

	// Response present, frozen, nothing held yet
	assign capture_o = (ic_ack_i | ic_err_i) & freeze_i & !saved_i;

	// A flush in the same cycle throws the capture away
	assign saving_o = capture_o & !flush_i;

	////////////////////
	// Bypass
	////////////////////

	logic bypass_q;
	logic bypass;

	// Set by flush, held until an address with bit 0 high shows up
	// Bit 0 clears it in that very cycle
	assign bypass = ic_adr_i[0] ? 1'b0 : (bypass_q | flush_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= bypass;
		end
	end

	////////////////////
	// Instruction and PC
	////////////////////

	always_comb begin
		if (no_more_dslot_i || rfe_i || bypass) begin
			insn_o = nop_flush;
		end else if (saved_i) begin
			// A held error never reaches decode as a real word
			insn_o = held_status_i.err ? nop_flush : held_word_i.insn;
		end else if (ic_ack_i) begin
			insn_o = ic_dat_i;
		end else begin
			insn_o = nop_empty;
		end
	end

	// Held address was aligned before it was stored
	assign pc_o = saved_i ? held_word_i.addr : {ic_adr_i[ADDR_W-1:2], 2'b00};

	// Nothing live and nothing held
	assign stall_o = !ic_ack_i & !ic_err_i & !saved_i;

	// New word arrives while the old one still waits
	// PC generator must ask for it again later
	assign refetch_o = saved_i & ic_ack_i;

	////////////////////
	// Exceptions
	////////////////////

	ic_status_t cur_status;

	// Held status wins while saved
	assign cur_status = saved_i ? held_status_i : '{err: ic_err_i, tag: ic_tag_i};

	// No delay slot left, so nothing may trap here
	assign exc_tlb_miss_o   = !no_more_dslot_i & cur_status.err &
		(cur_status.tag == tag_tlb_miss);
	assign exc_page_fault_o = !no_more_dslot_i & cur_status.err &
		(cur_status.tag == tag_page_fault);
	assign exc_bus_err_o    = !no_more_dslot_i & cur_status.err &
		(cur_status.tag == tag_bus_err);

endmodule

//--- verilog/freeze_hold.sv
// Holds one cache response per freeze. Flush wins over capture, and only the first capture of a freeze is kept.

`timescale 1ns/1ps

module freeze_hold #(
	// Payload kept across the freeze
	parameter type payload_t = logic,
	// Value after reset or flush
	parameter payload_t RESET_VAL = '0
) (
	input  logic     clk,
	input  logic     reset_i,
	// Pipeline flush clears everything held
	input  logic     flush_i,
	// Pipeline frozen this cycle
	input  logic     freeze_i,
	// Response present, frozen, nothing saved yet
	input  logic     capture_i,
	// Live payload from the cache port
	input  payload_t data_i,
	// Held payload valid while saved_o is high
	output payload_t held_o,
	// A response has been captured
	output logic     saved_o
);

	////////////////////
	// Saved flag
	////////////////////

	logic saved_q;

	// Set on capture
	// Dropped once the freeze ends
	always_ff @(posedge clk) begin
		if (reset_i || flush_i) begin
			saved_q <= 1'b0;
		end else if (capture_i) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			saved_q <= 1'b0;
		end
	end

	////////////////////
	// Payload register
	////////////////////

	payload_t held_q;

	// Flush first, then load on capture
	// Outside a freeze it tracks the live payload
	// so the address side is always current
	always_ff @(posedge clk) begin
		if (reset_i || flush_i) begin
			held_q <= RESET_VAL;
		end else if (capture_i || !freeze_i) begin
			held_q <= data_i;
		end
		// Frozen and already saved
		// keep the first response
	end

	////////////////////
	// Outputs
	////////////////////

	// Both straight from the registers
	assign held_o  = held_q;
	assign saved_o = saved_q;

endmodule

//--- verilog/if_pkg.sv
// Shared fetch-stage constants and payload types. The address field of fetch_word_t is addr_w wide, so any ADDR_W override must match it.

package if_pkg;

	////////////////////
	// Widths
	////////////////////

	// Instruction word width
	localparam int insn_w = 32;

	// Cache tag width
	localparam int tag_w = 4;

	// Default fetch address width, also the width of held addresses
	localparam int addr_w = 32;

	////////////////////
	// NOP encodings
	////////////////////

	// Opcode 000101 with immediate 041_0000
	// Used on flush, no delay slot left, and rfe
	localparam logic [insn_w-1:0] nop_flush = 32'h1441_0000;

	// Opcode 000101 with immediate 061_0000
	// Shown while the cache has nothing to give
	localparam logic [insn_w-1:0] nop_empty = 32'h1461_0000;

	////////////////////
	// Cache error tags
	////////////////////

	// Translation miss in the ITLB
	localparam logic [tag_w-1:0] tag_tlb_miss = 4'hd;

	// Page fault from the IMMU
	localparam logic [tag_w-1:0] tag_page_fault = 4'hc;

	// Bus error on the refill
	localparam logic [tag_w-1:0] tag_bus_err = 4'hb;

	// Any other tag with err raises no exception

	////////////////////
	// Hold payloads
	////////////////////

	// Word hold payload
	// Address is stored already word aligned
	typedef struct packed {
		logic [insn_w-1:0] insn;
		logic [addr_w-1:0] addr;
	} fetch_word_t;

	// Status hold payload
	// Tag only has meaning while err is set
	typedef struct packed {
		logic err;
		logic [tag_w-1:0] tag;
	} ic_status_t;

	// Word hold cleared state
	// Held insn reads as a flush NOP, address zero
	localparam fetch_word_t word_reset_val = '{
		insn: nop_flush,
		addr: '0
	};

	// Status hold cleared state
	localparam ic_status_t status_reset_val = '{
		err: 1'b0,
		tag: '0
	};

endpackage

//--- verilog/if_stage_top.sv
// Instruction-fetch stage top. ADDR_W must equal if_pkg::addr_w because the held word stores the address at that width.

`timescale 1ns/1ps

module if_stage_top
	import if_pkg::*;
#(
	// Fetch address width, passed down to the issue block
	parameter int ADDR_W = 32
) (
	input  logic              clk,
	input  logic              reset_i,

	// Cache CPU port
	input  logic [insn_w-1:0] ic_dat_i,
	input  logic              ic_ack_i,
	input  logic              ic_err_i,
	input  logic [ADDR_W-1:0] ic_adr_i,
	input  logic [tag_w-1:0]  ic_tag_i,

	// Pipeline controls
	input  logic              freeze_i,
	input  logic              flush_i,
	input  logic              no_more_dslot_i,
	input  logic              rfe_i,

	// Stage outputs
	output logic [insn_w-1:0] insn_o,
	output logic [ADDR_W-1:0] pc_o,
	output logic              stall_o,
	output logic              saving_o,
	output logic              refetch_o,
	output logic              exc_tlb_miss_o,
	output logic              exc_page_fault_o,
	output logic              exc_bus_err_o
);

	////////////////////
	// Live payloads
	////////////////////

	fetch_word_t live_word;
	ic_status_t  live_status;

	// Word is stored with its address already aligned
	assign live_word   = '{insn: ic_dat_i, addr: {ic_adr_i[ADDR_W-1:2], 2'b00}};
	assign live_status = '{err: ic_err_i, tag: ic_tag_i};

	////////////////////
	// Hold blocks
	////////////////////

	logic        capture;
	logic        saved;
	fetch_word_t held_word;
	ic_status_t  held_status;

	// Instruction word and address
	freeze_hold #(
		.payload_t (fetch_word_t),
		.RESET_VAL (word_reset_val)
	) u_word_hold (
		.clk       (clk),
		.reset_i   (reset_i),
		.flush_i   (flush_i),
		.freeze_i  (freeze_i),
		.capture_i (capture),
		.data_i    (live_word),
		.held_o    (held_word),
		.saved_o   (saved)
	);

	// Err and tag, same capture so both stay in step
	// Its flag copies the word flag and is left open
	freeze_hold #(
		.payload_t (ic_status_t),
		.RESET_VAL (status_reset_val)
	) u_status_hold (
		.clk       (clk),
		.reset_i   (reset_i),
		.flush_i   (flush_i),
		.freeze_i  (freeze_i),
		.capture_i (capture),
		.data_i    (live_status),
		.held_o    (held_status),
		.saved_o   ()
	);

	////////////////////
	// Issue block
	////////////////////

	fetch_issue #(
		.ADDR_W (ADDR_W)
	) u_issue (
		.clk              (clk),
		.reset_i          (reset_i),
		.ic_dat_i         (ic_dat_i),
		.ic_ack_i         (ic_ack_i),
		.ic_err_i         (ic_err_i),
		.ic_adr_i         (ic_adr_i),
		.ic_tag_i         (ic_tag_i),
		.freeze_i         (freeze_i),
		.flush_i          (flush_i),
		.no_more_dslot_i  (no_more_dslot_i),
		.rfe_i            (rfe_i),
		.held_word_i      (held_word),
		.held_status_i    (held_status),
		.saved_i          (saved),
		.capture_o        (capture),
		.insn_o           (insn_o),
		.pc_o             (pc_o),
		.stall_o          (stall_o),
		.saving_o         (saving_o),
		.refetch_o        (refetch_o),
		.exc_tlb_miss_o   (exc_tlb_miss_o),
		.exc_page_fault_o (exc_page_fault_o),
		.exc_bus_err_o    (exc_bus_err_o)
	);

endmodule
